// File: common/ipv4_hdr_defs.svh
// Constants shared by the IPv4 header checker RTL and its testbench
// Include wherever field positions, latencies or register offsets are needed
`ifndef IPV4_HDR_DEFS_SVH
`define IPV4_HDR_DEFS_SVH

// Header geometry, first transmitted byte in the top bits
`define IPV4_HDR_BITS        160
`define IPV4_HDR_WORDS       10
`define IPV4_VERSION         4'd4
`define IPV4_IHL             4'd5
`define IPV4_VER_MSB         159
`define IPV4_IHL_MSB         155
`define IPV4_TTL_MSB         95

// Common protocol field values
`define IPV4_PROTO_ICMP      8'd1
`define IPV4_PROTO_TCP       8'd6
`define IPV4_PROTO_UDP       8'd17

// Pipeline latencies in clock cycles
`define CSUM_LATENCY         3
`define VERDICT_LATENCY      4

// APB register byte offsets
`define REG_CTRL             8'h00
`define REG_RX_COUNT         8'h04
`define REG_PASS_COUNT       8'h08
`define REG_CSUM_ERR_COUNT   8'h0C
`define REG_FIELD_ERR_COUNT  8'h10

`endif

// File: common/ipv4_hdr_pkg.sv
// Vector types shared across the IPv4 header checker
// Compile before any module that names these types
`default_nettype none

`include "ipv4_hdr_defs.svh"

package ipv4_hdr_pkg;

    ////////////////////
    // Header path

    // Whole 20-byte header, version nibble in the top bits
    typedef logic [`IPV4_HDR_BITS-1:0] ipv4_hdr_t;

    // One 16-bit header word or checksum
    typedef logic [15:0] csum_t;

    ////////////////////
    // Register path

    // APB byte address
    typedef logic [7:0] apb_addr_t;

    // APB data word
    typedef logic [31:0] apb_data_t;

    // Statistics counter, wraps on overflow
    typedef logic [31:0] stat_count_t;

endpackage

`default_nettype wire

// File: ipv4_checksum/ipv4_checksum_verify.sv
// Three-stage pipelined ones'-complement check of a 20-byte IPv4 header
// csum_ok is valid with csum_valid, CSUM_LATENCY cycles after hdr_valid
`default_nettype none

`include "ipv4_hdr_defs.svh"

module ipv4_checksum_verify (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    hdr_valid,
    input  wire ipv4_hdr_pkg::ipv4_hdr_t hdr_data,
    output logic                         csum_valid,
    output logic                         csum_ok
);

    import ipv4_hdr_pkg::*;

    localparam int PAIRS = `IPV4_HDR_WORDS / 2;

    // Pair sum keeps one carry bit
    typedef logic [16:0] pair_sum_t;
    // Five pair sums stay below 2^20
    typedef logic [19:0] hdr_sum_t;

    csum_t       word [`IPV4_HDR_WORDS];
    pair_sum_t   pair_sum_q [PAIRS];
    hdr_sum_t    total_d;
    hdr_sum_t    total_q;
    logic [16:0] fold1;
    csum_t       fold2;
    logic        s1_valid;
    logic        s2_valid;

    // Split the header into big-endian words
    always_comb begin
        for (int i = 0; i < `IPV4_HDR_WORDS; i++) begin
            word[i] = hdr_data[`IPV4_HDR_BITS-1-16*i -: 16];
        end
    end

    ////////////////////
    // Stage 1

    // Adjacent words added in pairs
    always_ff @(posedge clk) begin
        for (int k = 0; k < PAIRS; k++) begin
            pair_sum_q[k] <= {1'b0, word[2*k]} + {1'b0, word[2*k+1]};
        end
    end

    ////////////////////
    // Stage 2

    always_comb begin
        total_d = '0;
        for (int k = 0; k < PAIRS; k++) begin
            total_d = total_d + hdr_sum_t'(pair_sum_q[k]);
        end
    end

    always_ff @(posedge clk) begin
        total_q <= total_d;
    end

    ////////////////////
    // Stage 3

    // First fold can carry once more, the second cannot
    always_comb begin
        fold1 = {1'b0, total_q[15:0]} + 17'(total_q[19:16]);
        fold2 = fold1[15:0] + 16'(fold1[16]);
    end

    // Valid header sums to all ones
    always_ff @(posedge clk) begin
        csum_ok <= (fold2 == 16'hFFFF);
    end

    // Valid bits travel alongside the sums
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid   <= 1'b0;
            s2_valid   <= 1'b0;
            csum_valid <= 1'b0;
        end else begin
            s1_valid   <= hdr_valid;
            s2_valid   <= s1_valid;
            csum_valid <= s2_valid;
        end
    end

endmodule

`default_nettype wire

// File: ipv4_hdr_checker.f
+incdir+common
common/ipv4_hdr_pkg.sv
ipv4_checksum/ipv4_checksum_verify.sv
source/ipv4_hdr_screen.sv
source/ipv4_stat_regs.sv
source/ipv4_hdr_checker.sv
verif/ipv4_hdr_checker_checker.sv
verif/ipv4_hdr_checker_tb.sv

// File: source/ipv4_hdr_checker.sv
// Top level of the receive-side IPv4 header checker
// One full header per hdr_valid, verdict four cycles later, stats over APB
`default_nettype none

module ipv4_hdr_checker (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    hdr_valid,
    input  wire ipv4_hdr_pkg::ipv4_hdr_t hdr_data,
    input  wire logic                    psel,
    input  wire logic                    penable,
    input  wire logic                    pwrite,
    input  wire ipv4_hdr_pkg::apb_addr_t paddr,
    input  wire ipv4_hdr_pkg::apb_data_t pwdata,
    output ipv4_hdr_pkg::apb_data_t      prdata,
    output logic                         pready,
    output logic                         pslverr,
    output logic                         verdict_valid,
    output logic                         verdict_pass,
    output logic                         verdict_csum_err,
    output logic                         verdict_field_err
);

    logic csum_valid;
    logic csum_ok;
    logic ttl_check_en;

    ipv4_checksum_verify u_csum (
        .clk        (clk),
        .rst_n      (rst_n),
        .hdr_valid  (hdr_valid),
        .hdr_data   (hdr_data),
        .csum_valid (csum_valid),
        .csum_ok    (csum_ok)
    );

    // Field checks run beside the checksum pipeline
    ipv4_hdr_screen u_screen (
        .clk               (clk),
        .rst_n             (rst_n),
        .hdr_valid         (hdr_valid),
        .hdr_data          (hdr_data),
        .ttl_check_en      (ttl_check_en),
        .csum_valid        (csum_valid),
        .csum_ok           (csum_ok),
        .verdict_valid     (verdict_valid),
        .verdict_pass      (verdict_pass),
        .verdict_csum_err  (verdict_csum_err),
        .verdict_field_err (verdict_field_err)
    );

    ipv4_stat_regs u_regs (
        .clk               (clk),
        .rst_n             (rst_n),
        .psel              (psel),
        .penable           (penable),
        .pwrite            (pwrite),
        .paddr             (paddr),
        .pwdata            (pwdata),
        .prdata            (prdata),
        .pready            (pready),
        .pslverr           (pslverr),
        .verdict_valid     (verdict_valid),
        .verdict_pass      (verdict_pass),
        .verdict_csum_err  (verdict_csum_err),
        .verdict_field_err (verdict_field_err),
        .ttl_check_en      (ttl_check_en)
    );

endmodule

`default_nettype wire

// File: source/ipv4_hdr_screen.sv
// Version, IHL and TTL field checks for each incoming header
// Merges the field result with csum_ok into one registered verdict
`default_nettype none

`include "ipv4_hdr_defs.svh"

module ipv4_hdr_screen (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    hdr_valid,
    input  wire ipv4_hdr_pkg::ipv4_hdr_t hdr_data,
    input  wire logic                    ttl_check_en,
    input  wire logic                    csum_valid,
    input  wire logic                    csum_ok,
    output logic                         verdict_valid,
    output logic                         verdict_pass,
    output logic                         verdict_csum_err,
    output logic                         verdict_field_err
);

    logic [3:0]               hdr_version;
    logic [3:0]               hdr_ihl;
    logic [7:0]               hdr_ttl;
    logic                     version_bad;
    logic                     ihl_bad;
    logic                     ttl_bad;
    logic                     field_err_in;
    logic [`CSUM_LATENCY-1:0] field_err_dly;
    logic                     field_err_aligned;

    ////////////////////
    // Field checks

    assign hdr_version = hdr_data[`IPV4_VER_MSB -: 4];
    assign hdr_ihl     = hdr_data[`IPV4_IHL_MSB -: 4];
    assign hdr_ttl     = hdr_data[`IPV4_TTL_MSB -: 8];

    assign version_bad = (hdr_version != `IPV4_VERSION);
    assign ihl_bad     = (hdr_ihl != `IPV4_IHL);
    // Zero TTL only counts when software enabled the check
    assign ttl_bad     = ttl_check_en && (hdr_ttl == 8'd0);

    assign field_err_in = hdr_valid && (version_bad || ihl_bad || ttl_bad);

    ////////////////////
    // Alignment

    // Matches the checksum pipeline depth
    always_ff @(posedge clk) begin
        field_err_dly <= {field_err_dly[`CSUM_LATENCY-2:0], field_err_in};
    end

    assign field_err_aligned = field_err_dly[`CSUM_LATENCY-1];

    ////////////////////
    // Verdict

    // Flags are only ever high together with verdict_valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            verdict_valid     <= 1'b0;
            verdict_pass      <= 1'b0;
            verdict_csum_err  <= 1'b0;
            verdict_field_err <= 1'b0;
        end else begin
            verdict_valid     <= csum_valid;
            verdict_pass      <= csum_valid && csum_ok && !field_err_aligned;
            verdict_csum_err  <= csum_valid && !csum_ok;
            verdict_field_err <= csum_valid && field_err_aligned;
        end
    end

endmodule

`default_nettype wire

// File: source/ipv4_stat_regs.sv
// APB slave with the checker control register and four statistics counters
// No wait states, unmapped offsets answer with pslverr
`default_nettype none

`include "ipv4_hdr_defs.svh"

module ipv4_stat_regs (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    psel,
    input  wire logic                    penable,
    input  wire logic                    pwrite,
    input  wire ipv4_hdr_pkg::apb_addr_t paddr,
    input  wire ipv4_hdr_pkg::apb_data_t pwdata,
    output ipv4_hdr_pkg::apb_data_t      prdata,
    output logic                         pready,
    output logic                         pslverr,
    input  wire logic                    verdict_valid,
    input  wire logic                    verdict_pass,
    input  wire logic                    verdict_csum_err,
    input  wire logic                    verdict_field_err,
    output logic                         ttl_check_en
);

    import ipv4_hdr_pkg::*;

    localparam int NUM_CNT       = 4;
    localparam int CNT_RX        = 0;
    localparam int CNT_PASS      = 1;
    localparam int CNT_CSUM_ERR  = 2;
    localparam int CNT_FIELD_ERR = 3;

    stat_count_t        count [NUM_CNT];
    logic [NUM_CNT-1:0] count_inc;
    logic               clear_pend;
    logic               access;
    logic               wr_ctrl;
    logic               addr_hit;
    apb_data_t          rd_word;

    ////////////////////
    // APB decode

    assign pready  = 1'b1;
    assign access  = psel && penable;
    assign wr_ctrl = access && pwrite && (paddr == `REG_CTRL);

    always_comb begin
        addr_hit = 1'b1;
        rd_word  = '0;
        case (paddr)
            // Clear bit reads back as 0
            `REG_CTRL:            rd_word = {31'd0, ttl_check_en};
            `REG_RX_COUNT:        rd_word = count[CNT_RX];
            `REG_PASS_COUNT:      rd_word = count[CNT_PASS];
            `REG_CSUM_ERR_COUNT:  rd_word = count[CNT_CSUM_ERR];
            `REG_FIELD_ERR_COUNT: rd_word = count[CNT_FIELD_ERR];
            default:              addr_hit = 1'b0;
        endcase
    end

    assign prdata = (access && !pwrite) ? rd_word : '0;

    ////////////////////
    // Control

    // pslverr set up during the setup phase so it shows in the access phase
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ttl_check_en <= 1'b0;
            clear_pend   <= 1'b0;
            pslverr      <= 1'b0;
        end else begin
            pslverr    <= psel && !penable && !addr_hit;
            clear_pend <= wr_ctrl && pwdata[1];
            if (wr_ctrl) begin
                ttl_check_en <= pwdata[0];
            end
        end
    end

    ////////////////////
    // Statistics

    assign count_inc[CNT_RX]        = verdict_valid;
    assign count_inc[CNT_PASS]      = verdict_valid && verdict_pass;
    assign count_inc[CNT_CSUM_ERR]  = verdict_valid && verdict_csum_err;
    assign count_inc[CNT_FIELD_ERR] = verdict_valid && verdict_field_err;

    // Clear takes priority over a verdict in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_CNT; i++) begin
                count[i] <= '0;
            end
        end else if (clear_pend) begin
            for (int i = 0; i < NUM_CNT; i++) begin
                count[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_CNT; i++) begin
                if (count_inc[i]) begin
                    count[i] <= count[i] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/ipv4_hdr_checker_checker.sv
// Concurrent assertions on the verdict path and the APB slave
// Attached to every ipv4_hdr_checker instance through bind
`default_nettype none

`include "ipv4_hdr_defs.svh"

module ipv4_hdr_checker_checker (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic hdr_valid,
    input wire logic verdict_valid,
    input wire logic verdict_pass,
    input wire logic verdict_csum_err,
    input wire logic verdict_field_err,
    input wire logic psel,
    input wire logic penable,
    input wire logic pready,
    input wire logic pslverr
);

    // No wait states on APB
    a_pready_high: assert property (@(posedge clk) disable iff (!rst_n) pready)
        else $error("pready went low");

    a_pass_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        verdict_pass |-> !(verdict_csum_err || verdict_field_err))
        else $error("verdict_pass together with an error flag");

    ////////////////////
    // Fixed latency

    a_verdict_follows: assert property (@(posedge clk) disable iff (!rst_n)
        hdr_valid |-> ##`VERDICT_LATENCY verdict_valid)
        else $error("verdict_valid missing after hdr_valid");

    a_verdict_source: assert property (@(posedge clk) disable iff (!rst_n)
        verdict_valid |-> $past(hdr_valid, `VERDICT_LATENCY))
        else $error("verdict_valid without a matching hdr_valid");

    a_pslverr_access: assert property (@(posedge clk) disable iff (!rst_n)
        pslverr |-> (psel && penable))
        else $error("pslverr outside the access phase");

endmodule

bind ipv4_hdr_checker ipv4_hdr_checker_checker u_checker (
    .clk               (clk),
    .rst_n             (rst_n),
    .hdr_valid         (hdr_valid),
    .verdict_valid     (verdict_valid),
    .verdict_pass      (verdict_pass),
    .verdict_csum_err  (verdict_csum_err),
    .verdict_field_err (verdict_field_err),
    .psel              (psel),
    .penable           (penable),
    .pready            (pready),
    .pslverr           (pslverr)
);

`default_nettype wire

// File: verif/ipv4_hdr_checker_tb.sv
// Self-checking testbench for the IPv4 header checker
// Drives headers and APB accesses, compares every verdict and counter readback
`default_nettype none

`include "ipv4_hdr_defs.svh"

module ipv4_hdr_checker_tb;

    import ipv4_hdr_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int CSUM_MSB      = 79;
    localparam int N_GOOD        = 12;
    localparam int N_CORRUPT     = 12;
    localparam int N_FIELD       = 5;
    localparam int N_TTL         = 3;
    localparam int N_B2B         = 16;
    localparam int TOTAL_HEADERS = N_GOOD + N_CORRUPT + N_FIELD + N_TTL + N_B2B;
    localparam int APB_ACCESSES  = 14;
    localparam int TIMEOUT       = (TOTAL_HEADERS + APB_ACCESSES) * CLK_PERIOD * 4;

    // Field error cases, one bit per header of test 3
    localparam logic [4:0] FIELD_VER_BAD  = 5'b01101;
    localparam logic [4:0] FIELD_IHL_BAD  = 5'b10110;
    localparam logic [4:0] FIELD_CSUM_BAD = 5'b11000;

    logic        clk;
    logic        rst_n;
    logic        hdr_valid;
    ipv4_hdr_t   hdr_data;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_addr_t   paddr;
    apb_data_t   pwdata;
    apb_data_t   prdata;
    logic        pready;
    logic        pslverr;
    logic        verdict_valid;
    logic        verdict_pass;
    logic        verdict_csum_err;
    logic        verdict_field_err;

    logic [31:0] lfsr_state = 32'h6382b2ef;
    int          cycle = 0;
    int          error_count = 0;
    int          check_count = 0;
    int          test_num = 1;
    int          errors_at_start = 0;
    logic        ttl_model = 1'b0;
    logic [2:0]  exp_flags_q [$];
    int          exp_cycle_q [$];
    stat_count_t tally_rx = '0;
    stat_count_t tally_pass = '0;
    stat_count_t tally_csum = '0;
    stat_count_t tally_field = '0;

    ipv4_hdr_checker dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .hdr_valid         (hdr_valid),
        .hdr_data          (hdr_data),
        .psel              (psel),
        .penable           (penable),
        .pwrite            (pwrite),
        .paddr             (paddr),
        .pwdata            (pwdata),
        .prdata            (prdata),
        .pready            (pready),
        .pslverr           (pslverr),
        .verdict_valid     (verdict_valid),
        .verdict_pass      (verdict_pass),
        .verdict_csum_err  (verdict_csum_err),
        .verdict_field_err (verdict_field_err)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    ////////////////////
    // Stimulus helpers

    // Taps 32, 22, 2, 1, one step per bit
    function automatic logic [31:0] random_bits(int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [3:0] other_nibble(logic [3:0] good);
        logic [3:0] v;
        v = 4'(random_bits(4));
        if (v == good) v = v + 4'd1;
        return v;
    endfunction

    // Folded ones'-complement sum of the ten header words
    function automatic csum_t ones_sum(ipv4_hdr_t h);
        logic [31:0] acc;
        acc = '0;
        for (int i = 0; i < `IPV4_HDR_WORDS; i++) begin
            acc = acc + 32'(h[`IPV4_HDR_BITS-1-16*i -: 16]);
        end
        while (acc[31:16] != 16'd0) acc = 32'(acc[15:0]) + 32'(acc[31:16]);
        return acc[15:0];
    endfunction

    function automatic ipv4_hdr_t make_header(logic [3:0] ver, logic [3:0] ihl,
                                              logic [7:0] ttl, logic bad_csum);
        ipv4_hdr_t h;
        logic [7:0] proto;
        csum_t good;
        csum_t csum;
        proto = random_bits(1) ? `IPV4_PROTO_TCP
              : (random_bits(1) ? `IPV4_PROTO_UDP : `IPV4_PROTO_ICMP);
        h = {ver, ihl, 8'(random_bits(8)), 16'd20 + 16'(random_bits(10)),
             16'(random_bits(16)), 16'h4000, ttl, proto, 16'h0000,
             random_bits(32), random_bits(32)};
        good = ~ones_sum(h);
        csum = good;
        if (bad_csum) begin
            csum = 16'(random_bits(16));
            if (csum == good) csum = csum + 16'd1;
        end
        h[CSUM_MSB -: 16] = csum;
        return h;
    endfunction

    // Expected {pass, csum_err, field_err} for one header
    function automatic logic [2:0] expected_verdict(ipv4_hdr_t h, logic ttl_en);
        logic csum_err;
        logic field_err;
        csum_err  = (ones_sum(h) != 16'hFFFF);
        field_err = (h[`IPV4_VER_MSB -: 4] != `IPV4_VERSION)
                 || (h[`IPV4_IHL_MSB -: 4] != `IPV4_IHL)
                 || (ttl_en && (h[`IPV4_TTL_MSB -: 8] == 8'd0));
        return {!csum_err && !field_err, csum_err, field_err};
    endfunction

    ////////////////////
    // Compare tasks

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Fail at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input apb_data_t got, input apb_data_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_latency(input string name, input int got, input int exp);
        check_count++;
        if (got != exp) begin
            error_count++;
            $display("Fail at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    ////////////////////
    // Drivers

    task automatic send_header(input ipv4_hdr_t h, input logic gap);
        logic [2:0] exp;
        @(negedge clk);
        hdr_valid = 1'b1;
        hdr_data  = h;
        exp = expected_verdict(h, ttl_model);
        exp_flags_q.push_back(exp);
        exp_cycle_q.push_back(cycle);
        tally_rx++;
        if (exp[2]) tally_pass++;
        if (exp[1]) tally_csum++;
        if (exp[0]) tally_field++;
        if (gap) begin
            @(negedge clk);
            hdr_valid = 1'b0;
        end
    endtask

    task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t data,
                              input apb_data_t exp_rd, input logic exp_err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        // Mid low phase, away from both edges
        #(CLK_PERIOD / 4);
        check_flag("pready", pready, 1'b1);
        check_flag("pslverr", pslverr, exp_err);
        if (!wr) check_word("prdata", prdata, exp_rd);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic finish_test(input string name);
        @(negedge clk);
        hdr_valid = 1'b0;
        while (exp_flags_q.size() != 0) @(negedge clk);
        $display("Test %0d (%s) done, %0d errors", test_num, name,
                 error_count - errors_at_start);
        test_num++;
        errors_at_start = error_count;
    endtask

    // Verdict compare, outputs settle well before the falling edge
    always @(negedge clk) begin : compare_verdicts
        logic [2:0] exp;
        int         sent;
        if (rst_n && verdict_valid) begin
            if (exp_flags_q.size() == 0) begin
                error_count++;
                $display("Error at %0t: verdict_valid seen with no header outstanding", $time);
            end else begin
                exp  = exp_flags_q.pop_front();
                sent = exp_cycle_q.pop_front();
                check_flag("verdict_pass", verdict_pass, exp[2]);
                check_flag("verdict_csum_err", verdict_csum_err, exp[1]);
                check_flag("verdict_field_err", verdict_field_err, exp[0]);
                check_latency("verdict latency", cycle - sent, `VERDICT_LATENCY);
            end
        end
    end

    initial begin
        #(TIMEOUT);
        $display("Error: watchdog expired before all tests finished");
        $display("sim failed");
        $finish;
    end

    ////////////////////
    // Test sequence

    initial begin
        rst_n     = 1'b0;
        hdr_valid = 1'b0;
        hdr_data  = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < N_GOOD; i++) begin
            send_header(make_header(`IPV4_VERSION, `IPV4_IHL, 8'(random_bits(8)) | 8'h01,
                                    1'b0), i[0]);
        end
        finish_test("good headers");

        for (int i = 0; i < N_CORRUPT; i++) begin
            send_header(make_header(`IPV4_VERSION, `IPV4_IHL, 8'(random_bits(8)) | 8'h01,
                                    1'b1), i[0]);
        end
        finish_test("corrupted checksum");

        for (int i = 0; i < N_FIELD; i++) begin
            send_header(make_header(
                FIELD_VER_BAD[i] ? other_nibble(`IPV4_VERSION) : `IPV4_VERSION,
                FIELD_IHL_BAD[i] ? other_nibble(`IPV4_IHL) : `IPV4_IHL,
                8'(random_bits(8)) | 8'h01, FIELD_CSUM_BAD[i]), 1'b0);
        end
        finish_test("field errors");

        // Zero TTL passes until the check is enabled
        send_header(make_header(`IPV4_VERSION, `IPV4_IHL, 8'd0, 1'b0), 1'b1);
        apb_access(1'b1, `REG_CTRL, 32'h1, '0, 1'b0);
        ttl_model = 1'b1;
        apb_access(1'b0, `REG_CTRL, '0, 32'h1, 1'b0);
        send_header(make_header(`IPV4_VERSION, `IPV4_IHL, 8'd0, 1'b0), 1'b1);
        send_header(make_header(`IPV4_VERSION, `IPV4_IHL, 8'd64, 1'b0), 1'b1);
        finish_test("ttl check");

        for (int i = 0; i < N_B2B; i++) begin
            send_header(make_header(
                (random_bits(3) == 0) ? other_nibble(`IPV4_VERSION) : `IPV4_VERSION,
                `IPV4_IHL, 8'(random_bits(8)) | 8'h01, random_bits(1) != 0), 1'b0);
        end
        finish_test("back-to-back");

        apb_access(1'b0, `REG_RX_COUNT, '0, tally_rx, 1'b0);
        apb_access(1'b0, `REG_PASS_COUNT, '0, tally_pass, 1'b0);
        apb_access(1'b0, `REG_CSUM_ERR_COUNT, '0, tally_csum, 1'b0);
        apb_access(1'b0, `REG_FIELD_ERR_COUNT, '0, tally_field, 1'b0);
        // Clear bit set, TTL check turned off in the same write
        apb_access(1'b1, `REG_CTRL, 32'h2, '0, 1'b0);
        ttl_model = 1'b0;
        apb_access(1'b0, `REG_RX_COUNT, '0, '0, 1'b0);
        apb_access(1'b0, `REG_PASS_COUNT, '0, '0, 1'b0);
        apb_access(1'b0, `REG_CSUM_ERR_COUNT, '0, '0, 1'b0);
        apb_access(1'b0, `REG_FIELD_ERR_COUNT, '0, '0, 1'b0);
        apb_access(1'b1, 8'h20, 32'hFFFF_FFFF, '0, 1'b1);
        apb_access(1'b0, 8'h20, '0, '0, 1'b1);
        apb_access(1'b0, `REG_CTRL, '0, '0, 1'b0);
        finish_test("counters and decode");

        $display("Tests: %0d, checks: %0d, errors: %0d", test_num - 1, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
